// File: sim/hello_cases.txt
// each row holds x y kind in hex
// kind 1 = sprite pixel   0 = clear glyph bit inside a sprite box   2 = blanking
09E 0D0 1  // H top left pixel
0D5 0D7 1
0B6 0EB 1  // H crossbar
10E 0D0 1
106 0E8 1  // E middle bar end
14E 100 1
16D 0E0 1
1A6 0D0 1
1CE 0F0 1
1CD 107 1  // O lower curve
0AE 0D0 0
0DD 0E8 0  // last pixel of the H box
0BE 10F 0  // blank bottom row
0EE 0D8 0
10E 0EF 0
13E 0E0 0
19E 0D0 0
1B6 0E8 0  // inside the O
280 0D0 2
2BC 064 2
31F 20C 2
064 1EA 2
000 1E0 2

// File: hello_display.f
design/hello_pkg.sv
design/display_timings.sv
design/glyph_rom.sv
design/sprite.sv
design/starfield.sv
design/hello_display.sv
sim/tb_hello_display.sv

// File: run_sim.sh
#!/bin/sh
# Build the HELLO display testbench with Verilator and run it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hello_display \
    -f hello_display.f \
    -o tb_hello_display

out=$(./obj_dir/tb_hello_display)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// File: sim/tb_hello_display.sv
/* Testbench for hello_display. Follows the raster with its own counters, checks sync
   and data enable on every pixel, and checks colour at probe points from sim/hello_cases.txt. */

`default_nettype none

module tb_hello_display;
    import hello_pkg::*;

    localparam int H_FULL       = 800;
    localparam int V_FULL       = 525;
    localparam int H_RES        = 640;
    localparam int V_RES        = 480;
    localparam int HS_FIRST     = 656;
    localparam int HS_LAST      = 751;
    localparam int VS_FIRST     = 490;
    localparam int VS_LAST      = 491;
    localparam int FRAME_CYCLES = H_FULL * V_FULL;
    localparam int RUN_FRAMES   = 2;
    localparam int TIMEOUT      = 3 * FRAME_CYCLES;  // a third frame of slack
    localparam int MAX_CASES    = 64;

    logic    clk_pix;
    logic    rst;
    logic    dvi_hsync;
    logic    dvi_vsync;
    logic    dvi_de;
    colour_t dvi_r;
    colour_t dvi_g;
    colour_t dvi_b;

    logic [11:0] case_mem [3*MAX_CASES];  // x, y, kind triples
    int          probe_x [MAX_CASES];
    int          probe_y [MAX_CASES];
    int          probe_kind [MAX_CASES];
    logic [11:0] probe_rgb [RUN_FRAMES][MAX_CASES];
    int          n_cases = 0;
    int          timing_errs = 0;
    int          colour_errs = 0;
    int          probe_errs = 0;
    int          cycles = 0;

    hello_display DUT (
        .clk_pix(clk_pix),
        .rst(rst),
        .dvi_hsync(dvi_hsync),
        .dvi_vsync(dvi_vsync),
        .dvi_de(dvi_de),
        .dvi_r(dvi_r),
        .dvi_g(dvi_g),
        .dvi_b(dvi_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;
    end

    task automatic load_cases();
        for (int i = 0; i < 3 * MAX_CASES; i++) begin
            case_mem[i] = 12'hFFF;  // marks unused entries
        end
        $readmemh("sim/hello_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_mem[3*n_cases+2] != 12'hFFF) begin
            probe_x[n_cases]    = int'(case_mem[3*n_cases]);
            probe_y[n_cases]    = int'(case_mem[3*n_cases+1]);
            probe_kind[n_cases] = int'(case_mem[3*n_cases+2]);
            if (probe_x[n_cases] >= H_FULL || probe_y[n_cases] >= V_FULL
                    || probe_kind[n_cases] > 2) begin
                $display("case %0d is not a valid probe: x %0d y %0d kind %0d", n_cases,
                         probe_x[n_cases], probe_y[n_cases], probe_kind[n_cases]);
                probe_errs++;
            end
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no probe points were read from sim/hello_cases.txt");
            probe_errs++;
        end
    endtask

    task automatic compare_level(input string sig, input int x, input int y,
                                 input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s at %0d,%0d: expected %b, actual %b",
                     sig, x, y, expected, actual);
            timing_errs++;
        end
    endtask

    // syncs inactive and de high while the counters sit at 0,0
    task automatic check_reset_state(input string when);
        compare_level({"hsync ", when}, 0, 0, 1'b1, dvi_hsync);
        compare_level({"vsync ", when}, 0, 0, 1'b1, dvi_vsync);
        compare_level({"de ", when}, 0, 0, 1'b1, dvi_de);
    endtask

    task automatic check_raster(input int x, input int y);
        compare_level("hsync", x, y, !(x >= HS_FIRST && x <= HS_LAST), dvi_hsync);
        compare_level("vsync", x, y, !(y >= VS_FIRST && y <= VS_LAST), dvi_vsync);
        compare_level("de", x, y, (x < H_RES && y < V_RES), dvi_de);
    endtask

    // blanking taken from the raster position, not from the DUT's de
    task automatic verify_blanking(input int x, input int y);
        if (!(x < H_RES && y < V_RES) && {dvi_r, dvi_g, dvi_b} !== 12'h000) begin
            $display("Mismatch blank rgb at %0d,%0d: expected 000, actual %h",
                     x, y, {dvi_r, dvi_g, dvi_b});
            colour_errs++;
        end
    endtask

    task automatic score_probe(input int i, input int f);
        logic [11:0] rgb;
        string       name;
        rgb  = {dvi_r, dvi_g, dvi_b};
        name = $sformatf("probe %0d (%0d,%0d) frame %0d", i, probe_x[i], probe_y[i], f + 1);
        probe_rgb[f][i] = rgb;
        if (probe_kind[i] == 1) begin
            if (rgb !== SPRITE_RGB) begin
                $display("Mismatch %s sprite: expected %h, actual %h", name, SPRITE_RGB, rgb);
                probe_errs++;
            end
        end else if (probe_kind[i] == 0) begin
            if (dvi_g !== dvi_r || dvi_b !== dvi_r) begin  // stars are grey
                $display("Mismatch %s grey: expected %h, actual %h", name, {3{dvi_r}}, rgb);
                probe_errs++;
            end
            if (rgb === SPRITE_RGB) begin
                $display("%s shows the sprite colour where the glyph bit is clear", name);
                probe_errs++;
            end
        end else begin
            if (dvi_de !== 1'b0) begin
                $display("%s should lie in blanking but data enable is high", name);
                probe_errs++;
            end
            if (rgb !== 12'h000) begin
                $display("Mismatch %s blank: expected 000, actual %h", name, rgb);
                probe_errs++;
            end
        end
    endtask

    task automatic compare_frames();
        for (int i = 0; i < n_cases; i++) begin
            if (probe_rgb[1][i] !== probe_rgb[0][i]) begin
                $display("Mismatch probe %0d (%0d,%0d) repeat: expected %h, actual %h",
                         i, probe_x[i], probe_y[i], probe_rgb[0][i], probe_rgb[1][i]);
                probe_errs++;
            end
        end
    endtask

    task automatic print_summary();
        $display("probes %0d  timing errors %0d  colour errors %0d  probe errors %0d",
                 n_cases, timing_errs, colour_errs, probe_errs);
    endtask

    initial begin : stimulus
        int x;
        int y;
        int f;
        rst = 1'b1;
        load_cases();
        repeat (2) begin
            @(negedge clk_pix);
            check_reset_state("during reset");
        end
        rst = 1'b0;  // this cycle already shows pixel 0,0
        x = 0;
        y = 0;
        f = 0;
        while (f < RUN_FRAMES) begin
            if (f == 0 && y == 0 && x == 0) begin
                check_reset_state("after reset");
            end
            check_raster(x, y);
            verify_blanking(x, y);
            for (int i = 0; i < n_cases; i++) begin
                if (probe_x[i] == x && probe_y[i] == y) begin
                    score_probe(i, f);
                end
            end
            if (x == H_FULL - 1) begin  // end of line
                x = 0;
                if (y == V_FULL - 1) begin
                    y = 0;
                    f++;
                end else begin
                    y++;
                end
            end else begin
                x++;
            end
            @(negedge clk_pix);  // outputs settled since the rising edge
        end
        compare_frames();
        print_summary();
        if (timing_errs + colour_errs + probe_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycles < TIMEOUT) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout after %0d cycles before the second frame was done", cycles);
        print_summary();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/hello_display.sv
/* Top level of the HELLO test screen: five scaled glyph sprites over three
   scrolling star layers, driving sync, data enable and 4-bit RGB to a DVI encoder. */

`default_nettype none

module hello_display #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33,
    parameter int SCALE  = 8,
    parameter int SPR_Y  = 208
) (
    input  wire logic         clk_pix,
    input  wire logic         rst,
    output logic              dvi_hsync,
    output logic              dvi_vsync,
    output logic              dvi_de,
    output hello_pkg::colour_t dvi_r,
    output hello_pkg::colour_t dvi_g,
    output hello_pkg::colour_t dvi_b
);
    import hello_pkg::*;

    localparam int H_RES_FULL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_RES_FULL = V_RES + V_FP + V_SYNC + V_BP;
    localparam int SPR_CNT    = 5;

    // sprites start on the line before they are drawn
    localparam coord_t START_LINE = (SPR_Y == 0) ? coord_t'(V_RES_FULL - 1)
                                                 : coord_t'(SPR_Y - 1);

    localparam coord_t      SPR_X    [SPR_CNT] = '{158, 222, 286, 350, 414};
    localparam glyph_code_t SPR_CODE [SPR_CNT] = '{GLYPH_H, GLYPH_E, GLYPH_L, GLYPH_L, GLYPH_O};

    coord_t sx;
    coord_t sy;

    display_timings #(
        .H_RES(H_RES),
        .V_RES(V_RES),
        .H_FP(H_FP),
        .H_SYNC(H_SYNC),
        .H_BP(H_BP),
        .V_FP(V_FP),
        .V_SYNC(V_SYNC),
        .V_BP(V_BP)
    ) timings (
        .clk_pix,
        .rst,
        .sx,
        .sy,
        .hsync(dvi_hsync),
        .vsync(dvi_vsync),
        .de(dvi_de)
    );

    logic               spr_start;
    logic [SPR_CNT-1:0] spr_dma;   // one rom slot per sprite in h blanking
    logic [SPR_CNT-1:0] spr_pix;
    glyph_row_t         spr_row [SPR_CNT];
    glyph_addr_t        rom_addr;
    glyph_line_t        rom_data;

    always_comb begin
        spr_start = (sy == START_LINE) && (sx == '0);
        for (int k = 0; k < SPR_CNT; k++) begin
            spr_dma[k] = (sx == coord_t'(H_RES + k));
        end
    end

    // address comes from whichever sprite owns the slot
    always_comb begin
        rom_addr = '0;
        for (int k = 0; k < SPR_CNT; k++) begin
            if (spr_dma[k]) rom_addr = {SPR_CODE[k], spr_row[k]};
        end
    end

    glyph_rom font_rom (
        .clk_pix,
        .addr(rom_addr),
        .data(rom_data)
    );

    for (genvar i = 0; i < SPR_CNT; i++) begin : g_spr
        sprite #(
            .SCALE(SCALE),
            .H_RES_FULL(H_RES_FULL)
        ) spr (
            .clk_pix,
            .rst,
            .start(spr_start),
            .dma_avail(spr_dma[i]),
            .sx,
            .sprx(SPR_X[i]),
            .data_in(rom_data),
            .row(spr_row[i]),
            .pix(spr_pix[i])
        );
    end

    // three layers at different scroll speeds
    logic       sf1_on, sf2_on, sf3_on;
    logic [7:0] sf1_star, sf2_star, sf3_star;

    starfield #(.H(H_RES_FULL), .V(V_RES_FULL), .INC(-1), .SEED(21'h9A9A9)) sf1 (
        .clk_pix,
        .rst,
        .sf_on(sf1_on),
        .sf_star(sf1_star)
    );

    starfield #(.H(H_RES_FULL), .V(V_RES_FULL), .INC(-2), .SEED(21'hA9A9A)) sf2 (
        .clk_pix,
        .rst,
        .sf_on(sf2_on),
        .sf_star(sf2_star)
    );

    starfield #(.H(H_RES_FULL), .V(V_RES_FULL), .INC(-4), .MASK(21'h7FF)) sf3 (
        .clk_pix,
        .rst,
        .sf_on(sf3_on),
        .sf_star(sf3_star)
    );

    colour_t starlight;  // grey level of the front-most star

    always_comb begin
        starlight = sf1_on ? sf1_star[7:4] :
                    sf2_on ? sf2_star[7:4] :
                    sf3_on ? sf3_star[7:4] : 4'h0;
        if (!dvi_de) begin
            {dvi_r, dvi_g, dvi_b} = 12'h000;  // black in blanking
        end else if (spr_pix != '0) begin
            {dvi_r, dvi_g, dvi_b} = SPRITE_RGB;
        end else begin
            dvi_r = starlight;
            dvi_g = starlight;
            dvi_b = starlight;
        end
    end

endmodule

`default_nettype wire

// File: design/starfield.sv
/* Star layer from a 21-bit Galois LFSR, reseeded when its frame counter wraps.
   INC shortens or lengthens the period against the frame, so the stars scroll. */

`default_nettype none

module starfield #(
    parameter int          H    = 800,
    parameter int          V    = 525,
    parameter int          INC  = -1,
    parameter logic [20:0] SEED = 21'h1FFFFF,
    parameter logic [20:0] MASK = 21'hFFF
) (
    input  wire logic  clk_pix,
    input  wire logic  rst,
    output logic       sf_on,
    output logic [7:0] sf_star
);
    localparam logic [20:0] CNT_LAST = 21'(H * V + INC - 1);
    localparam logic [20:0] TAPS     = 21'b101000000000000000000;

    logic [20:0] sf_reg;
    logic [20:0] sf_cnt;

    always_ff @(posedge clk_pix) begin
        if (sf_cnt == CNT_LAST) begin  // reseed at counter wrap
            sf_cnt <= '0;
            sf_reg <= SEED;
        end else begin
            sf_cnt <= sf_cnt + 1'b1;
            sf_reg <= {1'b0, sf_reg[20:1]} ^ (sf_reg[0] ? TAPS : 21'b0);
        end
        if (rst) begin
            sf_cnt <= '0;
            sf_reg <= SEED;
        end
    end

    // star where every bit outside the mask is set
    always_comb begin
        sf_on   = &(sf_reg | MASK);
        sf_star = sf_reg[7:0];
    end

endmodule

`default_nettype wire

// File: design/sprite.sv
/* Sprite line engine: fetches one glyph row per line in its DMA slot and
   shifts it out with each pixel held SCALE clocks, each row shown SCALE lines. */

`default_nettype none

module sprite #(
    parameter int SCALE      = 8,
    parameter int H_RES_FULL = 800
) (
    input  wire logic                  clk_pix,
    input  wire logic                  rst,
    input  wire logic                  start,      // line before the first drawn line
    input  wire logic                  dma_avail,  // this sprite's rom slot
    input  wire hello_pkg::coord_t     sx,
    input  wire hello_pkg::coord_t     sprx,
    input  wire hello_pkg::glyph_line_t data_in,
    output hello_pkg::glyph_row_t      row,
    output logic                       pix
);
    import hello_pkg::*;

    localparam int SCLW = (SCALE > 1) ? $clog2(SCALE) : 1;
    localparam logic [SCLW-1:0] SCALE_LAST = SCLW'(SCALE - 1);
    localparam glyph_row_t ROW_LAST = '1;

    typedef enum logic [2:0] {
        IDLE,
        REG_POS,
        WAIT_POS,
        LINE,
        WAIT_DATA
    } state_t;

    state_t          state;
    coord_t          pos_trig;  // cycle before the first sprite pixel
    glyph_line_t     spr_line;  // fetched glyph row
    glyph_line_t     shift;     // working copy for the current line
    logic [2:0]      col;
    logic [SCLW-1:0] cnt_x;
    logic [SCLW-1:0] cnt_y;
    logic            dma_dly;   // rom data valid

    // pix is registered, so trigger one pixel early; wrap for sprx 0
    always_comb begin
        pos_trig = (sprx == '0) ? coord_t'(H_RES_FULL - 1) : sprx - 1'b1;
    end

    always_ff @(posedge clk_pix) begin
        dma_dly <= dma_avail;
        case (state)
            IDLE: begin
                if (start) begin
                    row   <= '0;
                    cnt_y <= '0;
                    state <= WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (dma_dly) begin
                    spr_line <= data_in;
                    state    <= REG_POS;
                end
            end
            REG_POS: begin
                shift <= spr_line;
                col   <= '0;
                cnt_x <= '0;
                state <= WAIT_POS;
            end
            WAIT_POS: begin
                if (sx == pos_trig) begin
                    pix   <= shift[7];
                    state <= LINE;
                end
            end
            LINE: begin
                if (cnt_x == SCALE_LAST) begin
                    cnt_x <= '0;
                    if (col == 3'd7) begin  // last column done
                        pix <= 1'b0;
                        if (cnt_y == SCALE_LAST) begin
                            cnt_y <= '0;
                            if (row == ROW_LAST) begin
                                state <= IDLE;
                            end else begin
                                row   <= row + 1'b1;  // fetched in this line's slot
                                state <= WAIT_DATA;
                            end
                        end else begin
                            cnt_y <= cnt_y + 1'b1;  // same row again
                            state <= REG_POS;
                        end
                    end else begin
                        col   <= col + 1'b1;
                        shift <= shift << 1;
                        pix   <= shift[6];
                    end
                end else begin
                    cnt_x <= cnt_x + 1'b1;
                    pix   <= shift[7];
                end
            end
            default: state <= IDLE;
        endcase
        if (rst) begin
            state   <= IDLE;
            row     <= '0;
            col     <= '0;
            cnt_x   <= '0;
            cnt_y   <= '0;
            pix     <= 1'b0;
            dma_dly <= 1'b0;
        end
    end

    // a start while drawing would restart the glyph before its last row
    assert property (@(posedge clk_pix) disable iff (rst) start |-> (state == IDLE))
        else $error("sprite: start while glyph row %0d is still drawing", row);

endmodule

`default_nettype wire

// File: design/glyph_rom.sv
/* Built-in 8x8 glyph table for the letters H, E, L and O.
   Registered read, data appears one clock after the address. */

`default_nettype none

module glyph_rom (
    input  wire logic                  clk_pix,
    input  wire hello_pkg::glyph_addr_t addr,
    output hello_pkg::glyph_line_t     data
);
    import hello_pkg::*;

    always_ff @(posedge clk_pix) begin
        case (addr)
            {GLYPH_H, 3'd0}: data <= 8'hC6;
            {GLYPH_H, 3'd1}: data <= 8'hC6;
            {GLYPH_H, 3'd2}: data <= 8'hC6;
            {GLYPH_H, 3'd3}: data <= 8'hFE;  // crossbar
            {GLYPH_H, 3'd4}: data <= 8'hC6;
            {GLYPH_H, 3'd5}: data <= 8'hC6;
            {GLYPH_H, 3'd6}: data <= 8'hC6;
            {GLYPH_E, 3'd0}: data <= 8'hFE;
            {GLYPH_E, 3'd1}: data <= 8'hC0;
            {GLYPH_E, 3'd2}: data <= 8'hC0;
            {GLYPH_E, 3'd3}: data <= 8'hFC;  // shorter middle bar
            {GLYPH_E, 3'd4}: data <= 8'hC0;
            {GLYPH_E, 3'd5}: data <= 8'hC0;
            {GLYPH_E, 3'd6}: data <= 8'hFE;
            {GLYPH_L, 3'd0}: data <= 8'hC0;
            {GLYPH_L, 3'd1}: data <= 8'hC0;
            {GLYPH_L, 3'd2}: data <= 8'hC0;
            {GLYPH_L, 3'd3}: data <= 8'hC0;
            {GLYPH_L, 3'd4}: data <= 8'hC0;
            {GLYPH_L, 3'd5}: data <= 8'hC0;
            {GLYPH_L, 3'd6}: data <= 8'hFE;
            {GLYPH_O, 3'd0}: data <= 8'h7C;
            {GLYPH_O, 3'd1}: data <= 8'hC6;
            {GLYPH_O, 3'd2}: data <= 8'hC6;
            {GLYPH_O, 3'd3}: data <= 8'hC6;
            {GLYPH_O, 3'd4}: data <= 8'hC6;
            {GLYPH_O, 3'd5}: data <= 8'hC6;
            {GLYPH_O, 3'd6}: data <= 8'h7C;
            default:         data <= 8'h00;  // row 7 is blank for every letter
        endcase
    end

    // the top's slot mux must always present a known address
    assert property (@(posedge clk_pix) !$isunknown(addr))
        else $error("glyph_rom: unknown address");

endmodule

`default_nettype wire

// File: design/display_timings.sv
/* Pixel and line counters for the display, with sync pulses and data enable.
   Outputs describe the pixel (sx, sy) of the current cycle. */

`default_nettype none

module display_timings #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  wire logic        clk_pix,
    input  wire logic        rst,
    output hello_pkg::coord_t sx,
    output hello_pkg::coord_t sy,
    output logic             hsync,
    output logic             vsync,
    output logic             de
);
    import hello_pkg::*;

    localparam int H_RES_FULL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_RES_FULL = V_RES + V_FP + V_SYNC + V_BP;

    localparam coord_t H_LAST = coord_t'(H_RES_FULL - 1);
    localparam coord_t V_LAST = coord_t'(V_RES_FULL - 1);
    localparam coord_t HS_STA = coord_t'(H_RES + H_FP);          // first sync pixel
    localparam coord_t HS_END = coord_t'(H_RES + H_FP + H_SYNC); // first pixel after sync
    localparam coord_t VS_STA = coord_t'(V_RES + V_FP);
    localparam coord_t VS_END = coord_t'(V_RES + V_FP + V_SYNC);
    localparam coord_t H_ACT  = coord_t'(H_RES);
    localparam coord_t V_ACT  = coord_t'(V_RES);

    // both syncs active low
    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);
        vsync = ~(sy >= VS_STA && sy < VS_END);
        de    = (sx < H_ACT) && (sy < V_ACT);
    end

    always_ff @(posedge clk_pix) begin
        if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end
    end

    // counters never escape the frame, even across many wraps
    assert property (@(posedge clk_pix) disable iff (rst) (sx <= H_LAST) && (sy <= V_LAST))
        else $error("display_timings: position %0d,%0d outside frame", sx, sy);

endmodule

`default_nettype wire

// File: design/hello_pkg.sv
/* Shared widths, glyph codes and sprite colour for the HELLO test screen.
   Imported by the design modules and by the testbench. */

`default_nettype none

package hello_pkg;

    // screen coordinates
    localparam int CORDW = 10;
    typedef logic [CORDW-1:0] coord_t;

    // one DVI colour channel
    typedef logic [3:0] colour_t;

    // glyph rows are 8 pixels, msb is the leftmost pixel
    typedef logic [7:0] glyph_line_t;
    typedef logic [2:0] glyph_row_t;   // row within a glyph
    typedef logic [1:0] glyph_code_t;  // letter index

    // rom address is {code, row}
    typedef logic [$bits(glyph_code_t)+$bits(glyph_row_t)-1:0] glyph_addr_t;

    localparam glyph_code_t GLYPH_H = 2'd0;
    localparam glyph_code_t GLYPH_E = 2'd1;
    localparam glyph_code_t GLYPH_L = 2'd2;
    localparam glyph_code_t GLYPH_O = 2'd3;

    // amber, {r, g, b}
    localparam logic [11:0] SPRITE_RGB = 12'hFC0;

endpackage

`default_nettype wire
